// File: design/overlay_cmd_pkg.sv
`default_nettype none

package overlay_cmd_pkg;

    // Host command opcodes
    typedef enum logic [7:0] {
        op_reset        = 8'h00,
        op_mode         = 8'h01,
        op_flags        = 8'h02,
        op_scale        = 8'h03,
        op_offset_x     = 8'h04,
        op_offset_y     = 8'h05,
        op_transparency = 8'h06,
        op_clip_left    = 8'h07,
        op_clip_right   = 8'h08,
        op_clip_top     = 8'h09,
        op_clip_bottom  = 8'h0A,
        op_freeze       = 8'h0B,
        op_upload       = 8'h0C,
        op_nop          = 8'hFF
    } cmd_op_t;

    typedef enum logic [1:0] {
        await_cmd   = 2'd0,
        await_arg_1 = 2'd1,
        await_arg_2 = 2'd2,
        issue       = 2'd3
    } cmd_state_t;

    // Argument bytes that follow an opcode
    function automatic logic [1:0] arg_count(input logic [7:0] op);
        case (op)
            8'h01, 8'h02, 8'h03, 8'h06, 8'h0B, 8'h0C: return 2'd1;
            8'h04, 8'h05, 8'h07, 8'h08, 8'h09, 8'h0A: return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/overlay_mix_pkg.sv
`default_nettype none

package overlay_mix_pkg;

    // Compositing mode of the foreground layer
    typedef enum logic [1:0] {
        bg_only   = 2'd0,
        fg_opaque = 2'd1,
        fg_blend  = 2'd2,
        fg_keyed  = 2'd3
    } mix_mode_t;

    // Right shift applied to foreground coordinates
    localparam int scale_w = 2;

    typedef logic [scale_w-1:0] scale_t;

    localparam int max_scale_shift = 2**scale_w - 1;

endpackage

`default_nettype wire

// File: design/spi_byte_rx.sv
`default_nettype none

module spi_byte_rx (
    input  wire  clk,
    input  wire  arst_n,
    input  wire  sclk,
    input  wire  ss_n,
    input  wire  mosi,
    output logic miso,
    output logic spi_active,
    output logic [7:0] rx_byte,
    output logic rx_valid
);

    // Two sync stages plus a third sclk bit for edge detect
    logic [2:0] sclk_sync;
    logic [1:0] ss_sync;
    logic [1:0] mosi_sync;
    logic [2:0] bit_cnt;
    logic [6:0] shift_q;
    logic [7:0] echo_q;
    logic       in_frame;
    logic       sclk_rise;
    logic       sclk_fall;

    assign in_frame  = ~ss_sync[1];
    assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
    assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
    assign miso      = echo_q[7];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sclk_sync  <= '0;
            ss_sync    <= 2'b11;
            mosi_sync  <= '0;
            bit_cnt    <= '0;
            echo_q     <= '0;
            spi_active <= 1'b0;
            rx_valid   <= 1'b0;
        end else begin
            sclk_sync  <= {sclk_sync[1:0], sclk};
            ss_sync    <= {ss_sync[0], ss_n};
            mosi_sync  <= {mosi_sync[0], mosi};
            spi_active <= in_frame;
            rx_valid   <= in_frame & sclk_rise & (bit_cnt == 3'd7);
            if (!in_frame) begin
                bit_cnt <= '0;
                echo_q  <= '0;
            end else begin
                if (sclk_rise) begin
                    bit_cnt <= bit_cnt + 3'd1;
                end
                // Counter at zero on a fall means a byte just finished
                if (sclk_fall) begin
                    echo_q <= (bit_cnt == 3'd0) ? rx_byte : {echo_q[6:0], 1'b0};
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_frame && sclk_rise) begin
            shift_q <= {shift_q[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {shift_q, mosi_sync[1]};
            end
        end
    end

    a_rx_in_frame: assert property (
        @(posedge clk) disable iff (!arst_n) rx_valid |-> spi_active && $past(spi_active)
    );

endmodule

`default_nettype wire

// File: design/overlay_cmd_decode.sv
`default_nettype none

module overlay_cmd_decode (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        spi_active,
    input  wire  [7:0] rx_byte,
    input  wire        rx_valid,
    output logic       cmd_valid,
    output overlay_cmd_pkg::cmd_op_t cmd_op,
    output logic [15:0] cmd_arg
);

    overlay_cmd_pkg::cmd_state_t state;
    overlay_cmd_pkg::cmd_op_t    op_q;
    logic [15:0]                 arg_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= overlay_cmd_pkg::await_cmd;
        end else if (!spi_active) begin
            // Frame ended, drop any partial command
            state <= overlay_cmd_pkg::await_cmd;
        end else begin
            case (state)
                overlay_cmd_pkg::await_cmd: begin
                    if (rx_valid) begin
                        if (overlay_cmd_pkg::arg_count(rx_byte) == 2'd0) begin
                            state <= overlay_cmd_pkg::issue;
                        end else begin
                            state <= overlay_cmd_pkg::await_arg_1;
                        end
                    end
                end
                overlay_cmd_pkg::await_arg_1: begin
                    if (rx_valid) begin
                        if (overlay_cmd_pkg::arg_count(op_q) == 2'd2) begin
                            state <= overlay_cmd_pkg::await_arg_2;
                        end else begin
                            state <= overlay_cmd_pkg::issue;
                        end
                    end
                end
                overlay_cmd_pkg::await_arg_2: begin
                    if (rx_valid) begin
                        state <= overlay_cmd_pkg::issue;
                    end
                end
                default: begin
                    state <= overlay_cmd_pkg::await_cmd;
                end
            endcase
        end
    end

    // High byte arrives first
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                overlay_cmd_pkg::await_cmd: begin
                    op_q <= overlay_cmd_pkg::cmd_op_t'(rx_byte);
                end
                overlay_cmd_pkg::await_arg_1: begin
                    arg_q <= {8'h00, rx_byte};
                end
                overlay_cmd_pkg::await_arg_2: begin
                    arg_q <= {arg_q[7:0], rx_byte};
                end
                default: begin
                end
            endcase
        end
    end

    assign cmd_valid = (state == overlay_cmd_pkg::issue);
    assign cmd_op    = op_q;
    assign cmd_arg   = arg_q;

    a_single_issue: assert property (
        @(posedge clk) disable iff (!arst_n) cmd_valid |=> !cmd_valid
    );

endmodule

`default_nettype wire

// File: design/overlay_ctrl_regs.sv
`default_nettype none

module overlay_ctrl_regs #(
    parameter int PRECISION              = 11,
    parameter int TRANSPARENCY_PRECISION = 3
) (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         cmd_valid,
    input  wire overlay_cmd_pkg::cmd_op_t cmd_op,
    input  wire  [15:0] cmd_arg,
    output overlay_mix_pkg::mix_mode_t mode,
    output overlay_mix_pkg::scale_t    scale,
    output logic signed [PRECISION:0]  offset_x,
    output logic signed [PRECISION:0]  offset_y,
    output logic [PRECISION-1:0]       clip_left,
    output logic [PRECISION-1:0]       clip_right,
    output logic [PRECISION-1:0]       clip_top,
    output logic [PRECISION-1:0]       clip_bottom,
    output logic [TRANSPARENCY_PRECISION-1:0] transparency
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode         <= overlay_mix_pkg::bg_only;
            scale        <= '0;
            offset_x     <= '0;
            offset_y     <= '0;
            clip_left    <= '0;
            clip_right   <= '0;
            clip_top     <= '0;
            clip_bottom  <= '0;
            transparency <= '0;
        end else if (cmd_valid) begin
            case (cmd_op)
                // Transparency survives the reset command
                overlay_cmd_pkg::op_reset: begin
                    mode        <= overlay_mix_pkg::bg_only;
                    scale       <= '0;
                    offset_x    <= '0;
                    offset_y    <= '0;
                    clip_left   <= '0;
                    clip_right  <= '0;
                    clip_top    <= '0;
                    clip_bottom <= '0;
                end
                overlay_cmd_pkg::op_mode: begin
                    mode <= overlay_mix_pkg::mix_mode_t'(cmd_arg[1:0]);
                end
                overlay_cmd_pkg::op_scale: scale <= cmd_arg[overlay_mix_pkg::scale_w-1:0];
                overlay_cmd_pkg::op_offset_x: offset_x <= cmd_arg[PRECISION:0];
                overlay_cmd_pkg::op_offset_y: offset_y <= cmd_arg[PRECISION:0];
                overlay_cmd_pkg::op_transparency: begin
                    transparency <= cmd_arg[TRANSPARENCY_PRECISION-1:0];
                end
                overlay_cmd_pkg::op_clip_left: clip_left <= cmd_arg[PRECISION-1:0];
                overlay_cmd_pkg::op_clip_right: clip_right <= cmd_arg[PRECISION-1:0];
                overlay_cmd_pkg::op_clip_top: clip_top <= cmd_arg[PRECISION-1:0];
                overlay_cmd_pkg::op_clip_bottom: clip_bottom <= cmd_arg[PRECISION-1:0];
                // Flags, freeze, upload and no-op are accepted and ignored
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/overlay_pixel_mix.sv
`default_nettype none

module overlay_pixel_mix #(
    parameter int PRECISION              = 11,
    parameter int TRANSPARENCY_PRECISION = 3,
    parameter int PIXEL_W                = 8
) (
    input  wire         clk,
    input  wire         arst_n,
    input  wire overlay_mix_pkg::mix_mode_t mode,
    input  wire overlay_mix_pkg::scale_t    scale,
    input  wire signed [PRECISION:0]        offset_x,
    input  wire signed [PRECISION:0]        offset_y,
    input  wire [PRECISION-1:0]             clip_left,
    input  wire [PRECISION-1:0]             clip_right,
    input  wire [PRECISION-1:0]             clip_top,
    input  wire [PRECISION-1:0]             clip_bottom,
    input  wire [TRANSPARENCY_PRECISION-1:0] transparency,
    input  wire                 pix_valid,
    input  wire [PRECISION-1:0] pix_x,
    input  wire [PRECISION-1:0] pix_y,
    input  wire [PIXEL_W-1:0]   bg_pixel,
    input  wire [PIXEL_W-1:0]   fg_pixel,
    output logic                 out_valid,
    output logic [PIXEL_W-1:0]   out_pixel,
    output logic [PRECISION-1:0] fg_fetch_x,
    output logic [PRECISION-1:0] fg_fetch_y,
    output logic                 in_window
);

    localparam int BLEND_W = PIXEL_W + TRANSPARENCY_PRECISION + 1;

    logic signed [PRECISION+1:0]        diff_x;
    logic signed [PRECISION+1:0]        diff_y;
    logic signed [PRECISION+1:0]        scaled_x;
    logic signed [PRECISION+1:0]        scaled_y;
    logic [TRANSPARENCY_PRECISION:0]    fg_weight;
    logic [BLEND_W-1:0]                 blend_sum;
    logic                               win;
    logic [PIXEL_W-1:0]                 mix_pixel;

    // Pixel position relative to the foreground origin with one guard bit
    assign diff_x   = $signed({2'b00, pix_x}) - $signed({offset_x[PRECISION], offset_x});
    assign diff_y   = $signed({2'b00, pix_y}) - $signed({offset_y[PRECISION], offset_y});
    assign scaled_x = diff_x >>> scale;
    assign scaled_y = diff_y >>> scale;

    assign win = (pix_x >= clip_left) && (pix_x < clip_right) &&
                 (pix_y >= clip_top) && (pix_y < clip_bottom);

    // Transparency weights the background
    assign fg_weight = {1'b1, {TRANSPARENCY_PRECISION{1'b0}}} - {1'b0, transparency};
    assign blend_sum = BLEND_W'(bg_pixel) * BLEND_W'(transparency) +
                       BLEND_W'(fg_pixel) * BLEND_W'(fg_weight);

    always_comb begin
        mix_pixel = bg_pixel;
        if (win) begin
            case (mode)
                overlay_mix_pkg::fg_opaque: mix_pixel = fg_pixel;
                overlay_mix_pkg::fg_blend: mix_pixel = blend_sum[TRANSPARENCY_PRECISION +: PIXEL_W];
                overlay_mix_pkg::fg_keyed: begin
                    if (fg_pixel != '0) begin
                        mix_pixel = fg_pixel;
                    end
                end
                default: mix_pixel = bg_pixel;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pix_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_valid) begin
            out_pixel  <= mix_pixel;
            fg_fetch_x <= scaled_x[PRECISION-1:0];
            fg_fetch_y <= scaled_y[PRECISION-1:0];
            in_window  <= win;
        end
    end

    // Background passes through outside the window in every mode
    a_bg_outside_window: assert property (
        @(posedge clk) disable iff (!arst_n)
            out_valid && !in_window |-> out_pixel == $past(bg_pixel)
    );

endmodule

`default_nettype wire

// File: design/overlay_ctrl_top.sv
`default_nettype none

module overlay_ctrl_top #(
    parameter int PRECISION              = 11,
    parameter int TRANSPARENCY_PRECISION = 3,
    parameter int PIXEL_W                = 8
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  spi_sclk,
    input  wire                  spi_ss_n,
    input  wire                  spi_mosi,
    output logic                 spi_miso,
    input  wire                  pix_valid,
    input  wire  [PRECISION-1:0] pix_x,
    input  wire  [PRECISION-1:0] pix_y,
    input  wire  [PIXEL_W-1:0]   bg_pixel,
    input  wire  [PIXEL_W-1:0]   fg_pixel,
    output logic                 out_valid,
    output logic [PIXEL_W-1:0]   out_pixel,
    output logic [PRECISION-1:0] fg_fetch_x,
    output logic [PRECISION-1:0] fg_fetch_y,
    output logic                 in_window
);

    logic                       spi_active;
    logic [7:0]                 rx_byte;
    logic                       rx_valid;
    logic                       cmd_valid;
    overlay_cmd_pkg::cmd_op_t   cmd_op;
    logic [15:0]                cmd_arg;
    overlay_mix_pkg::mix_mode_t mode;
    overlay_mix_pkg::scale_t    scale;
    logic signed [PRECISION:0]  offset_x;
    logic signed [PRECISION:0]  offset_y;
    logic [PRECISION-1:0]       clip_left;
    logic [PRECISION-1:0]       clip_right;
    logic [PRECISION-1:0]       clip_top;
    logic [PRECISION-1:0]       clip_bottom;
    logic [TRANSPARENCY_PRECISION-1:0] transparency;

    spi_byte_rx u_rx (
        .clk(clk), .arst_n(arst_n),
        .sclk(spi_sclk), .ss_n(spi_ss_n), .mosi(spi_mosi), .miso(spi_miso),
        .spi_active(spi_active), .rx_byte(rx_byte), .rx_valid(rx_valid)
    );

    overlay_cmd_decode u_decode (
        .clk(clk), .arst_n(arst_n),
        .spi_active(spi_active), .rx_byte(rx_byte), .rx_valid(rx_valid),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_arg(cmd_arg)
    );

    overlay_ctrl_regs #(
        .PRECISION(PRECISION),
        .TRANSPARENCY_PRECISION(TRANSPARENCY_PRECISION)
    ) u_regs (
        .clk(clk), .arst_n(arst_n),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_arg(cmd_arg),
        .mode(mode), .scale(scale), .offset_x(offset_x), .offset_y(offset_y),
        .clip_left(clip_left), .clip_right(clip_right),
        .clip_top(clip_top), .clip_bottom(clip_bottom),
        .transparency(transparency)
    );

    overlay_pixel_mix #(
        .PRECISION(PRECISION),
        .TRANSPARENCY_PRECISION(TRANSPARENCY_PRECISION),
        .PIXEL_W(PIXEL_W)
    ) u_mix (
        .clk(clk), .arst_n(arst_n),
        .mode(mode), .scale(scale), .offset_x(offset_x), .offset_y(offset_y),
        .clip_left(clip_left), .clip_right(clip_right),
        .clip_top(clip_top), .clip_bottom(clip_bottom),
        .transparency(transparency),
        .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y),
        .bg_pixel(bg_pixel), .fg_pixel(fg_pixel),
        .out_valid(out_valid), .out_pixel(out_pixel),
        .fg_fetch_x(fg_fetch_x), .fg_fetch_y(fg_fetch_y), .in_window(in_window)
    );

endmodule

`default_nettype wire

// File: sim/tb_overlay_ctrl.sv
`default_nettype none

module tb_overlay_ctrl;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PRECISION = 11;
    localparam int TRANSPARENCY_PRECISION = 3;
    localparam int PIXEL_W = 8;
    localparam int HALF_SCLK = 5;
    localparam int CYCLE_LIMIT = 40000;

    logic clk = 1'b0;
    logic arst_n;
    logic spi_sclk;
    logic spi_ss_n;
    logic spi_mosi;
    wire  spi_miso;
    logic pix_valid;
    logic [PRECISION-1:0] pix_x;
    logic [PRECISION-1:0] pix_y;
    logic [PIXEL_W-1:0]   bg_pixel;
    logic [PIXEL_W-1:0]   fg_pixel;
    wire                  out_valid;
    wire  [PIXEL_W-1:0]   out_pixel;
    wire  [PRECISION-1:0] fg_fetch_x;
    wire  [PRECISION-1:0] fg_fetch_y;
    wire                  in_window;

    // Reference copy of the overlay settings
    overlay_mix_pkg::mix_mode_t        m_mode;
    logic [1:0]                        m_scale;
    logic signed [PRECISION:0]         m_off_x;
    logic signed [PRECISION:0]         m_off_y;
    logic [PRECISION-1:0]              m_clip_l;
    logic [PRECISION-1:0]              m_clip_r;
    logic [PRECISION-1:0]              m_clip_t;
    logic [PRECISION-1:0]              m_clip_b;
    logic [TRANSPARENCY_PRECISION-1:0] m_transp;

    logic [7:0]  frame[$];
    logic [31:0] seed = 32'h5173;
    string       test_name;
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_run = 0;
    int          cycles = 0;
    int          round;
    int          n;

    overlay_ctrl_top #(
        .PRECISION(PRECISION),
        .TRANSPARENCY_PRECISION(TRANSPARENCY_PRECISION),
        .PIXEL_W(PIXEL_W)
    ) u_overlay_ctrl_top (
        .clk(clk), .arst_n(arst_n),
        .spi_sclk(spi_sclk), .spi_ss_n(spi_ss_n), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .pix_valid(pix_valid), .pix_x(pix_x), .pix_y(pix_y),
        .bg_pixel(bg_pixel), .fg_pixel(fg_pixel),
        .out_valid(out_valid), .out_pixel(out_pixel),
        .fg_fetch_x(fg_fetch_x), .fg_fetch_y(fg_fetch_y), .in_window(in_window)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // Upper half of the LCG state since the low bits repeat quickly
    function automatic logic [15:0] rand16();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:16];
    endfunction

    function automatic int arg_bytes(input logic [7:0] op);
        case (op)
            8'h01, 8'h02, 8'h03, 8'h06, 8'h0B, 8'h0C: return 1;
            8'h04, 8'h05, 8'h07, 8'h08, 8'h09, 8'h0A: return 2;
            default: return 0;
        endcase
    endfunction

    task automatic apply_cmd(input logic [7:0] op, input logic [15:0] arg);
        case (op)
            overlay_cmd_pkg::op_reset: begin
                m_mode = overlay_mix_pkg::bg_only;
                m_scale = '0;
                m_off_x = '0;
                m_off_y = '0;
                m_clip_l = '0;
                m_clip_r = '0;
                m_clip_t = '0;
                m_clip_b = '0;
            end
            overlay_cmd_pkg::op_mode: m_mode = overlay_mix_pkg::mix_mode_t'(arg[1:0]);
            overlay_cmd_pkg::op_scale: m_scale = arg[1:0];
            overlay_cmd_pkg::op_offset_x: m_off_x = arg[PRECISION:0];
            overlay_cmd_pkg::op_offset_y: m_off_y = arg[PRECISION:0];
            overlay_cmd_pkg::op_transparency: m_transp = arg[TRANSPARENCY_PRECISION-1:0];
            overlay_cmd_pkg::op_clip_left: m_clip_l = arg[PRECISION-1:0];
            overlay_cmd_pkg::op_clip_right: m_clip_r = arg[PRECISION-1:0];
            overlay_cmd_pkg::op_clip_top: m_clip_t = arg[PRECISION-1:0];
            overlay_cmd_pkg::op_clip_bottom: m_clip_b = arg[PRECISION-1:0];
            default: begin
            end
        endcase
    endtask

    // A command cut off at the end of a frame is dropped
    task automatic update_model();
        int i;
        int cnt;
        logic [15:0] arg;
        i = 0;
        while (i < frame.size()) begin
            cnt = arg_bytes(frame[i]);
            if (i + cnt >= frame.size()) begin
                break;
            end
            arg = 16'h0000;
            if (cnt == 1) begin
                arg = {8'h00, frame[i+1]};
            end else if (cnt == 2) begin
                arg = {frame[i+1], frame[i+2]};
            end
            apply_cmd(frame[i], arg);
            i = i + cnt + 1;
        end
    endtask

    task automatic add_cmd(input logic [7:0] op, input logic [15:0] arg);
        frame.push_back(op);
        if (arg_bytes(op) == 2) begin
            frame.push_back(arg[15:8]);
        end
        if (arg_bytes(op) >= 1) begin
            frame.push_back(arg[7:0]);
        end
    endtask

    task automatic add_random_cmd();
        logic [15:0] r;
        logic [15:0] val;
        logic [7:0]  op;
        r = rand16();
        val = rand16();
        case (r[3:0])
            4'd13: op = 8'hFF;
            4'd14, 4'd15: op = 8'h20 + {2'b00, r[9:4]};
            default: op = {4'h0, r[3:0]};
        endcase
        // Keep windows wide enough to catch the pixels
        if (op == 8'h07 || op == 8'h09) begin
            val = val % 128;
        end else if (op == 8'h08 || op == 8'h0A) begin
            val = 64 + val % 192;
        end
        add_cmd(op, val);
    endtask

    // SPI mode 0 master that reads miso just before each rising sclk
    task automatic send_frame();
        logic [7:0] echo;
        logic [7:0] prev;
        int k;
        int b;
        prev = 8'h00;
        @(posedge clk);
        spi_ss_n <= 1'b0;
        repeat (HALF_SCLK) @(posedge clk);
        for (k = 0; k < frame.size(); k++) begin
            for (b = 7; b >= 0; b--) begin
                spi_sclk <= 1'b0;
                spi_mosi <= frame[k][b];
                repeat (HALF_SCLK - 1) @(posedge clk);
                @(negedge clk);
                echo[b] = spi_miso;
                @(posedge clk);
                spi_sclk <= 1'b1;
                repeat (HALF_SCLK) @(posedge clk);
            end
            if (echo !== prev) begin
                $display("error %s miso: expected %h, actual %h", test_name, prev, echo);
                errors++;
            end
            prev = frame[k];
        end
        spi_sclk <= 1'b0;
        repeat (HALF_SCLK) @(posedge clk);
        spi_ss_n <= 1'b1;
        spi_mosi <= 1'b0;
        repeat (4) @(posedge clk);
        update_model();
        frame.delete();
    endtask

    task automatic send_pixel(input logic [PRECISION-1:0] x, input logic [PRECISION-1:0] y,
                              input logic [PIXEL_W-1:0] bg, input logic [PIXEL_W-1:0] fg);
        logic [PRECISION-1:0] exp_fx;
        logic [PRECISION-1:0] exp_fy;
        logic [PIXEL_W-1:0]   exp_pix;
        logic                 exp_win;
        int                   full;
        exp_win = (x >= m_clip_l) && (x < m_clip_r) && (y >= m_clip_t) && (y < m_clip_b);
        exp_fx = PRECISION'((int'(x) - int'(m_off_x)) >>> m_scale);
        exp_fy = PRECISION'((int'(y) - int'(m_off_y)) >>> m_scale);
        full = 1 << TRANSPARENCY_PRECISION;
        exp_pix = bg;
        if (exp_win) begin
            case (m_mode)
                overlay_mix_pkg::fg_opaque: exp_pix = fg;
                overlay_mix_pkg::fg_blend: begin
                    exp_pix = PIXEL_W'((int'(bg) * int'(m_transp) +
                              int'(fg) * (full - int'(m_transp))) >> TRANSPARENCY_PRECISION);
                end
                overlay_mix_pkg::fg_keyed: begin
                    if (fg != 0) begin
                        exp_pix = fg;
                    end
                end
                default: exp_pix = bg;
            endcase
        end
        @(posedge clk);
        pix_valid <= 1'b1;
        pix_x <= x;
        pix_y <= y;
        bg_pixel <= bg;
        fg_pixel <= fg;
        @(posedge clk);
        pix_valid <= 1'b0;
        @(negedge clk);
        if (out_valid !== 1'b1) begin
            $display("%s: out_valid stayed low one cycle after pix_valid", test_name);
            errors++;
        end
        if (out_pixel !== exp_pix) begin
            $display("error %s out_pixel: expected %h, actual %h", test_name, exp_pix, out_pixel);
            errors++;
        end
        if (in_window !== exp_win) begin
            $display("error %s in_window: expected %b, actual %b", test_name, exp_win, in_window);
            errors++;
        end
        if (fg_fetch_x !== exp_fx) begin
            $display("error %s fg_fetch_x: expected %h, actual %h", test_name, exp_fx, fg_fetch_x);
            errors++;
        end
        if (fg_fetch_y !== exp_fy) begin
            $display("error %s fg_fetch_y: expected %h, actual %h", test_name, exp_fy, fg_fetch_y);
            errors++;
        end
    endtask

    task automatic random_pixels(input int count);
        logic [15:0] a;
        logic [15:0] b;
        int i;
        for (i = 0; i < count; i++) begin
            a = rand16();
            b = rand16();
            // Some zero foreground for keyed mode
            send_pixel({3'b000, a[7:0]}, {3'b000, a[15:8]}, b[7:0],
                       (b[15:13] == 3'd0) ? 8'h00 : b[15:8]);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d mismatches", test_name, errors - errors_at_start);
        end
        tests_run++;
    endtask

    initial begin
        arst_n = 1'b0;
        spi_sclk = 1'b0;
        spi_ss_n = 1'b1;
        spi_mosi = 1'b0;
        pix_valid = 1'b0;
        pix_x = '0;
        pix_y = '0;
        bg_pixel = '0;
        fg_pixel = '0;
        apply_cmd(overlay_cmd_pkg::op_reset, 16'h0000);
        m_transp = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk);

        start_test("one_byte_cmds");
        add_cmd(overlay_cmd_pkg::op_clip_right, 16'd200);
        add_cmd(overlay_cmd_pkg::op_clip_bottom, 16'd200);
        send_frame();
        for (round = 0; round < 4; round++) begin
            add_cmd(overlay_cmd_pkg::op_mode, rand16());
            add_cmd(overlay_cmd_pkg::op_scale, rand16());
            add_cmd(overlay_cmd_pkg::op_transparency, rand16());
            send_frame();
            random_pixels(20);
        end
        end_test();

        start_test("two_byte_cmds");
        for (round = 0; round < 4; round++) begin
            add_cmd(overlay_cmd_pkg::op_offset_x, (round == 0) ? 16'hFFE0 : rand16());
            add_cmd(overlay_cmd_pkg::op_offset_y, (round == 0) ? 16'hFF81 : rand16());
            add_cmd(overlay_cmd_pkg::op_clip_left, rand16() % 128);
            add_cmd(overlay_cmd_pkg::op_clip_right, 64 + rand16() % 192);
            add_cmd(overlay_cmd_pkg::op_clip_top, rand16() % 128);
            add_cmd(overlay_cmd_pkg::op_clip_bottom, 64 + rand16() % 192);
            send_frame();
            random_pixels(25);
        end
        end_test();

        start_test("reset_cmd");
        add_cmd(overlay_cmd_pkg::op_transparency, 16'd5);
        add_cmd(overlay_cmd_pkg::op_mode, 16'd1);
        add_cmd(overlay_cmd_pkg::op_reset, 16'h0000);
        send_frame();
        random_pixels(10);
        // Open window with the mode left as the reset command set it
        add_cmd(overlay_cmd_pkg::op_clip_right, 16'h00FF);
        add_cmd(overlay_cmd_pkg::op_clip_bottom, 16'h00FF);
        send_frame();
        random_pixels(10);
        // Blend again without resending transparency
        add_cmd(overlay_cmd_pkg::op_mode, 16'd2);
        send_frame();
        random_pixels(10);
        end_test();

        start_test("aborted_frame");
        frame.push_back(overlay_cmd_pkg::op_offset_x);
        frame.push_back(8'h01);
        send_frame();
        random_pixels(10);
        add_cmd(overlay_cmd_pkg::op_offset_x, 16'h0010);
        send_frame();
        random_pixels(10);
        end_test();

        start_test("miso_echo");
        for (n = 0; n < 3; n++) begin
            add_cmd(overlay_cmd_pkg::op_flags, rand16());
        end
        send_frame();
        random_pixels(10);
        end_test();

        start_test("random_traffic");
        for (round = 0; round < 10; round++) begin
            add_cmd(overlay_cmd_pkg::op_mode, 16'(round % 4));
            add_random_cmd();
            add_random_cmd();
            send_frame();
            random_pixels(50);
        end
        end_test();

        $display("tests run %0d, mismatches %0d", tests_run, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
design/overlay_cmd_pkg.sv
design/overlay_mix_pkg.sv
design/spi_byte_rx.sv
design/overlay_cmd_decode.sv
design/overlay_ctrl_regs.sv
design/overlay_pixel_mix.sv
design/overlay_ctrl_top.sv
sim/tb_overlay_ctrl.sv

// File: Bender.yml
package:
  name: overlay_ctrl

sources:
  - design/overlay_cmd_pkg.sv
  - design/overlay_mix_pkg.sv
  - design/spi_byte_rx.sv
  - design/overlay_cmd_decode.sv
  - design/overlay_ctrl_regs.sv
  - design/overlay_pixel_mix.sv
  - design/overlay_ctrl_top.sv
  - target: simulation
    files:
      - sim/tb_overlay_ctrl.sv
